// ==== source/ucode_config.svh ====
// microcode engine sizing macros shared by the package and the RTL.

`ifndef UCODE_CONFIG_SVH
`define UCODE_CONFIG_SVH

// ====================
// datapath widths
// ====================
`define UCODE_GPR_W       16  // register and outbound message width.
`define UCODE_PC_W        6   // microcode address width, 64 instructions.
`define UCODE_INST_W      32  // raw instruction width.
`define UCODE_REG_ADDR_W  3   // register index width, 8 registers.

// ====================
// send flow control
// ====================
`define UCODE_CREDITS     4   // credits held by the engine out of reset.
`define UCODE_CREDIT_W    3   // credit counter width, holds 0 to UCODE_CREDITS.

`endif

// ==== source/ucode_pkg.sv ====
// microcode engine types, instruction encodings and field decode helpers.
`default_nettype none

`include "ucode_config.svh"

package ucode_pkg;

  typedef logic [`UCODE_GPR_W-1:0]      gpr_t;       // register or message value.
  typedef logic [`UCODE_PC_W-1:0]       pc_t;        // microcode address.
  typedef logic [`UCODE_INST_W-1:0]     inst_t;      // raw instruction word.
  typedef logic [`UCODE_REG_ADDR_W-1:0] reg_addr_t;  // register index.
  typedef logic [`UCODE_CREDIT_W-1:0]   credit_t;    // send credit count.

  // instruction layout, msb first.
  //   [31:28] opcode, [27:26] branch op,
  //   [25:23] rd, [22:20] ra, [19:17] rb, [16] unused,
  //   [15:0]  immediate. a branch target is the low 6 bits of the immediate.
  typedef enum logic [3:0] {
    e_op_nop    = 4'd0,
    e_op_movi   = 4'd1,  // rd = imm.
    e_op_add    = 4'd2,  // rd = ra + rb.
    e_op_addi   = 4'd3,  // rd = ra + imm.
    e_op_send   = 4'd4,  // message = ra, needs one credit.
    e_op_branch = 4'd5,  // if (ra op rb) goto target.
    e_op_halt   = 4'd6
  } opcode_e;

  typedef enum logic [1:0] {
    e_br_eq  = 2'd0,
    e_br_neq = 2'd1,
    e_br_lt  = 2'd2,  // unsigned compares only.
    e_br_le  = 2'd3
  } branch_op_e;

  typedef enum logic [1:0] {
    e_idle    = 2'd0,
    e_run     = 2'd1,
    e_halted  = 2'd2
  } exec_state_e;

  // field extraction, kept here so fetch and execute slice the word the same way.
  function automatic opcode_e inst_opcode(inst_t inst);
    return opcode_e'(inst[31:28]);
  endfunction

  function automatic branch_op_e inst_branch_op(inst_t inst);
    return branch_op_e'(inst[27:26]);
  endfunction

  function automatic reg_addr_t inst_rd(inst_t inst);
    return inst[25:23];
  endfunction

  function automatic reg_addr_t inst_ra(inst_t inst);
    return inst[22:20];
  endfunction

  function automatic reg_addr_t inst_rb(inst_t inst);
    return inst[19:17];
  endfunction

  function automatic gpr_t inst_imm(inst_t inst);
    return inst[15:0];
  endfunction

  function automatic pc_t inst_target(inst_t inst);
    return inst[5:0];
  endfunction

endpackage

`default_nettype wire

// ==== source/ucode_fetch.sv ====
// fetch stage with the pc, a writable instruction memory and static branch prediction.
`default_nettype none

`include "ucode_config.svh"

module ucode_fetch (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              start_i,
  input  logic              stall_i,        // execute is holding on a send without credit.
  input  logic              redirect_i,     // execute resolved a mispredict this cycle.
  input  ucode_pkg::pc_t    redirect_pc_i,
  input  logic              load_en_i,
  input  ucode_pkg::pc_t    load_addr_i,
  input  ucode_pkg::inst_t  load_data_i,
  input  logic              run_i,          // execute state is running.
  output ucode_pkg::inst_t  inst_o,
  output ucode_pkg::pc_t    inst_pc_o,
  output logic              pred_taken_o,
  output logic              inst_valid_o
);

  import ucode_pkg::*;

  localparam int unsigned imem_depth_lp = 1 << `UCODE_PC_W;

  inst_t imem [imem_depth_lp];  // microcode store, written only through the load port.

  pc_t   pc_q;         // address presented to the memory this cycle.
  pc_t   pc_n;
  inst_t rd_word;      // word leaving the memory array ahead of the output register.
  logic  rd_backward;  // rd_word is a branch whose target is at or below its own pc.

  inst_t inst_q;
  pc_t   inst_pc_q;
  logic  pred_q;
  logic  valid_q;

  // ====================
  // static prediction
  // ====================
  // backward branches are assumed to close loops, so they are predicted taken.
  // forward branches fall through.
  assign rd_word     = imem[pc_q];
  assign rd_backward = (inst_opcode(rd_word) == e_op_branch) &&
                       (inst_target(rd_word) <= pc_q);
  assign pc_n        = rd_backward ? inst_target(rd_word) : pc_t'(pc_q + 1'b1);

  // the program may only change while execute is idle or halted.
  always_ff @(posedge clk_i) begin
    if (load_en_i && !run_i) begin
      imem[load_addr_i] <= load_data_i;
    end
  end

  // ====================
  // pc and valid bit
  // ====================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q    <= '0;
      valid_q <= 1'b0;
    end else if (start_i && !run_i) begin
      pc_q    <= '0;    // every run begins at address zero.
      valid_q <= 1'b0;
    end else if (!run_i) begin
      valid_q <= 1'b0;  // nothing reaches execute while idle or halted.
    end else if (redirect_i) begin
      pc_q    <= redirect_pc_i;
      valid_q <= 1'b0;  // the word fetched on the wrong path is squashed.
    end else if (!stall_i) begin
      pc_q    <= pc_n;
      valid_q <= 1'b1;
    end
  end

  // registered memory read, which also carries the pc and prediction with the word.
  always_ff @(posedge clk_i) begin
    if (run_i && !stall_i) begin
      inst_q    <= rd_word;
      inst_pc_q <= pc_q;
      pred_q    <= rd_backward;
    end
  end

  assign inst_o       = inst_q;
  assign inst_pc_o    = inst_pc_q;
  assign pred_taken_o = pred_q & valid_q;  // a bubble never claims a taken prediction.
  assign inst_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== source/ucode_regfile.sv ====
// eight-entry register file with two combinational read ports and one write port.
`default_nettype none

`include "ucode_config.svh"

module ucode_regfile (
  input  logic                 clk_i,
  input  ucode_pkg::reg_addr_t ra_addr_i,
  input  ucode_pkg::reg_addr_t rb_addr_i,
  input  ucode_pkg::reg_addr_t wr_addr_i,
  input  logic                 wr_en_i,
  input  ucode_pkg::gpr_t      wr_data_i,
  output ucode_pkg::gpr_t      ra_data_o,
  output ucode_pkg::gpr_t      rb_data_o
);

  import ucode_pkg::*;

  localparam int unsigned num_regs_lp = 1 << `UCODE_REG_ADDR_W;

  gpr_t regs [num_regs_lp];  // entry 0 is never written.

  // writes land at the clock edge that ends the execute cycle.
  always_ff @(posedge clk_i) begin
    if (wr_en_i && (wr_addr_i != '0)) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // ====================
  // read ports
  // ====================
  // register 0 is the zero register, so its storage is never consulted.
  // a write in the same cycle is not forwarded, which execute does not need
  // since the next instruction reads only after the edge.
  assign ra_data_o = (ra_addr_i == '0) ? '0 : regs[ra_addr_i];
  assign rb_data_o = (rb_addr_i == '0) ? '0 : regs[rb_addr_i];

endmodule

`default_nettype wire

// ==== source/ucode_branch.sv ====
// branch unit that compares two operands, flags a misprediction and picks the next pc.
`default_nettype none

module ucode_branch (
  input  ucode_pkg::gpr_t        opd_a_i,
  input  ucode_pkg::gpr_t        opd_b_i,
  input  logic                   branch_i,           // a valid branch is in execute.
  input  logic                   predicted_taken_i,  // fetch already steered to the target.
  input  ucode_pkg::branch_op_e  branch_op_i,
  input  ucode_pkg::pc_t         execute_pc_i,
  input  ucode_pkg::pc_t         branch_target_i,
  output logic                   mispredict_o,
  output ucode_pkg::pc_t         pc_o
);

  import ucode_pkg::*;

  logic opd_eq;    // operands are equal.
  logic opd_lt;    // operand a is below operand b, unsigned.
  logic cond_met;  // the compare selected by branch_op_i holds.
  logic taken;     // the instruction really changes the flow.
  pc_t  pc_plus_one;

  assign opd_eq      = (opd_a_i == opd_b_i);
  assign opd_lt      = (opd_a_i < opd_b_i);
  assign pc_plus_one = pc_t'(execute_pc_i + 1'b1);

  // ====================
  // compare
  // ====================
  // gt and ge are not here; the assembler swaps the operands of lt and le instead.
  always_comb begin
    unique case (branch_op_i)
      e_br_eq:  cond_met = opd_eq;
      e_br_neq: cond_met = !opd_eq;
      e_br_lt:  cond_met = opd_lt;
      e_br_le:  cond_met = opd_lt | opd_eq;
      default:  cond_met = 1'b0;
    endcase
  end

  assign taken = branch_i & cond_met;

  // wrong in either direction: taken but fell through, or steered but not taken.
  assign mispredict_o = taken ^ predicted_taken_i;

  // correct successor of whatever is in execute; non-branches simply step by one.
  assign pc_o = taken ? branch_target_i : pc_plus_one;

endmodule

`default_nettype wire

// ==== source/ucode_execute.sv ====
// execute stage with decode, alu, writeback, send credits, halt and pipeline flush.
`default_nettype none

`include "ucode_config.svh"

module ucode_execute (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   start_i,
  input  ucode_pkg::inst_t       inst_i,
  input  ucode_pkg::pc_t         inst_pc_i,
  input  logic                   pred_taken_i,
  input  logic                   inst_valid_i,
  input  ucode_pkg::gpr_t        ra_data_i,
  input  ucode_pkg::gpr_t        rb_data_i,
  input  logic                   mispredict_i,
  input  ucode_pkg::pc_t         next_pc_i,
  input  logic                   credit_i,        // one returned credit per high cycle.
  output ucode_pkg::reg_addr_t   ra_addr_o,
  output ucode_pkg::reg_addr_t   rb_addr_o,
  output ucode_pkg::reg_addr_t   wr_addr_o,
  output logic                   wr_en_o,
  output ucode_pkg::gpr_t        wr_data_o,
  output logic                   branch_o,
  output ucode_pkg::branch_op_e  branch_op_o,
  output ucode_pkg::pc_t         branch_target_o,
  output logic                   run_o,
  output logic                   stall_o,
  output logic                   redirect_o,
  output ucode_pkg::pc_t         redirect_pc_o,
  output logic                   msg_valid_o,
  output ucode_pkg::gpr_t        msg_data_o,
  output logic                   halted_o
);

  import ucode_pkg::*;

  exec_state_e state_q;
  credit_t     credit_q;
  opcode_e     op;
  logic        fire;     // a live instruction is in execute this cycle.
  logic        is_send;
  logic        send_go;  // the send leaves now and spends a credit.
  logic        msg_valid_q;
  gpr_t        msg_data_q;

  assign op      = inst_opcode(inst_i);
  assign fire    = (state_q == e_run) && inst_valid_i;
  assign is_send = fire && (op == e_op_send);
  assign send_go = is_send && (credit_q != '0);
  assign stall_o = is_send && (credit_q == '0);  // both stages hold until a credit lands.

  // operand fields go straight to the register file, reads are combinational.
  assign ra_addr_o = inst_ra(inst_i);
  assign rb_addr_o = inst_rb(inst_i);
  assign wr_addr_o = inst_rd(inst_i);

  // ====================
  // alu and writeback
  // ====================
  always_comb begin
    unique case (op)
      e_op_movi: wr_data_o = inst_imm(inst_i);
      e_op_add:  wr_data_o = gpr_t'(ra_data_i + rb_data_i);  // wraps modulo 2^16.
      e_op_addi: wr_data_o = gpr_t'(ra_data_i + inst_imm(inst_i));
      default:   wr_data_o = ra_data_i;                      // not written back.
    endcase
  end

  assign wr_en_o = fire && ((op == e_op_movi) || (op == e_op_add) || (op == e_op_addi));

  // ====================
  // branch and flush
  // ====================
  assign branch_o        = fire && (op == e_op_branch);
  assign branch_op_o     = inst_branch_op(inst_i);
  assign branch_target_o = inst_target(inst_i);
  assign redirect_o      = branch_o && mispredict_i;
  // a taken guess can only be wrong by falling through, so its recovery pc is
  // formed here and stays off the compare path through the branch unit.
  assign redirect_pc_o   = pred_taken_i ? pc_t'(inst_pc_i + 1'b1) : next_pc_i;

  // credits come back one per pulse and leave one per send.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_q <= credit_t'(`UCODE_CREDITS);
    end else begin
      unique case ({credit_i, send_go})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;  // none, or one in and one out.
      endcase
    end
  end

  // outbound message is registered so the port is free of decode glitches.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      msg_valid_q <= 1'b0;
    end else begin
      msg_valid_q <= send_go;
    end
  end

  always_ff @(posedge clk_i) begin
    if (send_go) begin
      msg_data_q <= ra_data_i;
    end
  end

  // ====================
  // control fsm
  // ====================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= e_idle;
    end else begin
      unique case (state_q)
        e_idle:   if (start_i) state_q <= e_run;
        e_run:    if (fire && (op == e_op_halt)) state_q <= e_halted;
        e_halted: if (start_i) state_q <= e_run;  // restart also clears the halt.
        default:  state_q <= e_idle;
      endcase
    end
  end

  assign run_o       = (state_q == e_run);
  assign halted_o    = (state_q == e_halted);
  assign msg_valid_o = msg_valid_q;
  assign msg_data_o  = msg_data_q;

endmodule

`default_nettype wire

// ==== source/ucode_engine.sv ====
// microcode engine top joining fetch, execute, the register file and the branch unit.
`default_nettype none

module ucode_engine (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              load_en_i,    // program write, taken only when not running.
  input  ucode_pkg::pc_t    load_addr_i,
  input  ucode_pkg::inst_t  load_data_i,
  input  logic              start_i,      // run from pc 0, also leaves halted.
  output logic              msg_valid_o,
  output ucode_pkg::gpr_t   msg_data_o,
  input  logic              credit_i,
  output logic              halted_o
);

  import ucode_pkg::*;

  // ====================
  // stage wiring
  // ====================
  inst_t      inst;
  pc_t        inst_pc;
  logic       pred_taken;
  logic       inst_valid;
  logic       run;
  logic       stall;
  logic       redirect;
  pc_t        redirect_pc;
  reg_addr_t  ra_addr;
  reg_addr_t  rb_addr;
  reg_addr_t  wr_addr;
  logic       wr_en;
  gpr_t       wr_data;
  gpr_t       ra_data;
  gpr_t       rb_data;
  logic       branch;
  branch_op_e branch_op;
  pc_t        branch_target;
  logic       mispredict;
  pc_t        next_pc;

  ucode_fetch fetch (
    .clk_i(clk_i), .rst_i(rst_i), .start_i(start_i),
    .stall_i(stall), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
    .load_en_i(load_en_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i),
    .run_i(run),
    .inst_o(inst), .inst_pc_o(inst_pc), .pred_taken_o(pred_taken),
    .inst_valid_o(inst_valid)
  );

  ucode_regfile regfile (
    .clk_i(clk_i),
    .ra_addr_i(ra_addr), .rb_addr_i(rb_addr),
    .wr_addr_i(wr_addr), .wr_en_i(wr_en), .wr_data_i(wr_data),
    .ra_data_o(ra_data), .rb_data_o(rb_data)
  );

  // operands come straight off the read ports, so a branch resolves in its execute cycle.
  ucode_branch branch_unit (
    .opd_a_i(ra_data), .opd_b_i(rb_data),
    .branch_i(branch), .predicted_taken_i(pred_taken), .branch_op_i(branch_op),
    .execute_pc_i(inst_pc), .branch_target_i(branch_target),
    .mispredict_o(mispredict), .pc_o(next_pc)
  );

  ucode_execute execute (
    .clk_i(clk_i), .rst_i(rst_i), .start_i(start_i),
    .inst_i(inst), .inst_pc_i(inst_pc), .pred_taken_i(pred_taken),
    .inst_valid_i(inst_valid),
    .ra_data_i(ra_data), .rb_data_i(rb_data),
    .mispredict_i(mispredict), .next_pc_i(next_pc), .credit_i(credit_i),
    .ra_addr_o(ra_addr), .rb_addr_o(rb_addr),
    .wr_addr_o(wr_addr), .wr_en_o(wr_en), .wr_data_o(wr_data),
    .branch_o(branch), .branch_op_o(branch_op), .branch_target_o(branch_target),
    .run_o(run), .stall_o(stall), .redirect_o(redirect), .redirect_pc_o(redirect_pc),
    .msg_valid_o(msg_valid_o), .msg_data_o(msg_data_o), .halted_o(halted_o)
  );

endmodule

`default_nettype wire

// ==== tb/ucode_engine_asserts.sv ====
// bound checker for the credit, reset, halt and squash rules of the microcode engine.
`default_nettype none

module ucode_engine_asserts (
  input logic                clk_i,
  input logic                rst_i,
  input logic                start_i,
  input logic                msg_valid_i,
  input logic                halted_i,
  input logic                redirect_i,    // execute resolved a mispredict this cycle.
  input logic                wr_en_i,
  input ucode_pkg::credit_t  credit_cnt_i   // execute credit counter.
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned failures_seen = 0;  // assertion failures so far.

  // ====================
  // flow control
  // ====================
  // a message on the port was sent in the previous cycle, which needed a credit then.
  msg_needs_credit: assert property (@(posedge clk_i) disable iff (rst_i)
    msg_valid_i |-> ($past(credit_cnt_i) != '0))
    else begin
      $error("message left the engine while its credit counter was zero");
      failures_seen++;
    end

  msg_quiet_in_reset: assert property (@(posedge clk_i)
    rst_i |=> !msg_valid_i)
    else begin
      $error("message valid seen while reset was applied");
      failures_seen++;
    end

  // ====================
  // halt and squash
  // ====================
  halt_sticks: assert property (@(posedge clk_i) disable iff (rst_i)
    (halted_i && !start_i) |=> halted_i)
    else begin
      $error("halted dropped without a start pulse");
      failures_seen++;
    end

  // the word behind a mispredict reaches execute as a bubble. it may not write
  // the register file, and the cycle after it may not show a message.
  squash_is_silent: assert property (@(posedge clk_i) disable iff (rst_i)
    redirect_i |=> (!wr_en_i ##1 !msg_valid_i))
    else begin
      $error("squashed instruction wrote a register or sent a message");
      failures_seen++;
    end

endmodule

`default_nettype wire

// ==== tb/ucode_engine_tb.sv ====
// testbench for the microcode engine, running table driven programs against a credit model.
`default_nettype none

`include "ucode_config.svh"

module ucode_engine_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import ucode_pkg::*;

  localparam int clk_half_lp   = 50;
  localparam int num_fixed_lp  = 15;
  localparam int num_random_lp = 8;
  localparam int num_rows_lp   = num_fixed_lp + num_random_lp;
  localparam int credits_lp    = `UCODE_CREDITS;

  typedef enum int {k_arith, k_fwd, k_loop} kind_e;

  typedef struct {
    kind_e      kind;
    branch_op_e bop;
    gpr_t       a;        // first operand, or the loop bound for a loop row.
    gpr_t       b;
    bit         hold;     // withhold returned credits until the first sends drain them.
    gpr_t       exp_val;  // a+b, the branch message, or the last loop count.
  } row_t;

  logic  clk;
  logic  rst;
  logic  load_en;
  pc_t   load_addr;
  inst_t load_data;
  logic  start;
  logic  credit;
  logic  msg_valid;
  gpr_t  msg_data;
  logic  halted;

  row_t        rows [num_rows_lp];
  inst_t       prog_q [$];
  gpr_t        exp_q [$];
  gpr_t        got_q [$];
  int          owed_q [$];  // cycles left before each outstanding credit goes back.
  bit          hold_credits;
  logic [31:0] rng_state = 32'd71;
  int          error_count;
  int          row_errors;
  int          rows_passed;

  ucode_engine uut (
    .clk_i(clk), .rst_i(rst),
    .load_en_i(load_en), .load_addr_i(load_addr), .load_data_i(load_data),
    .start_i(start),
    .msg_valid_o(msg_valid), .msg_data_o(msg_data),
    .credit_i(credit),
    .halted_o(halted)
  );

  bind ucode_engine ucode_engine_asserts asserts (
    .clk_i(clk_i), .rst_i(rst_i), .start_i(start_i),
    .msg_valid_i(msg_valid_o), .halted_i(halted_o),
    .redirect_i(redirect), .wr_en_i(wr_en),
    .credit_cnt_i(execute.credit_q)
  );

  initial clk = 1'b0;
  always #(clk_half_lp) clk = ~clk;  // 100 ns period.

  // ====================
  // helpers
  // ====================
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // opcode, branch op, rd, ra, rb, a spare bit, then the 16-bit immediate.
  function automatic inst_t encode(opcode_e op, branch_op_e bop, reg_addr_t rd,
                                   reg_addr_t ra, reg_addr_t rb, gpr_t imm);
    return {op, bop, rd, ra, rb, 1'b0, imm};
  endfunction

  // reference compare, all operands taken as unsigned.
  function automatic bit branch_holds(branch_op_e op, gpr_t a, gpr_t b);
    int unsigned ua;
    int unsigned ub;
    ua = a;
    ub = b;
    case (op)
      e_br_eq:  return ua == ub;
      e_br_neq: return ua != ub;
      e_br_lt:  return ua < ub;
      default:  return ua <= ub;
    endcase
  endfunction

  function automatic string kind_name(kind_e k);
    case (k)
      k_arith: return "arith";
      k_fwd:   return "forward branch";
      default: return "loop";
    endcase
  endfunction

  task automatic fill_table();
    int k;
    logic [31:0] r1;
    logic [31:0] r2;
    rows[0]  = '{k_arith, e_br_eq,  16'h1234, 16'h4321, 1'b0, 16'h5555};
    rows[1]  = '{k_arith, e_br_eq,  16'hfff0, 16'h0025, 1'b0, 16'h0015};  // wraps.
    rows[2]  = '{k_fwd,   e_br_eq,  16'h0007, 16'h0007, 1'b0, 16'd1};
    rows[3]  = '{k_fwd,   e_br_eq,  16'h0007, 16'h0008, 1'b0, 16'd2};
    rows[4]  = '{k_fwd,   e_br_neq, 16'h0003, 16'h0009, 1'b0, 16'd1};
    rows[5]  = '{k_fwd,   e_br_neq, 16'h0009, 16'h0009, 1'b0, 16'd2};
    rows[6]  = '{k_fwd,   e_br_lt,  16'h0001, 16'h8000, 1'b0, 16'd1};  // signed would fail.
    rows[7]  = '{k_fwd,   e_br_lt,  16'h8000, 16'h0001, 1'b0, 16'd2};
    rows[8]  = '{k_fwd,   e_br_le,  16'h0005, 16'h0005, 1'b0, 16'd1};
    rows[9]  = '{k_fwd,   e_br_le,  16'h0003, 16'hfffe, 1'b0, 16'd1};
    rows[10] = '{k_fwd,   e_br_le,  16'hffff, 16'h0000, 1'b0, 16'd2};
    rows[11] = '{k_loop,  e_br_lt,  16'd1,    16'd0,    1'b0, 16'd0};
    rows[12] = '{k_loop,  e_br_lt,  16'd3,    16'd0,    1'b0, 16'd2};
    rows[13] = '{k_loop,  e_br_lt,  16'd7,    16'd0,    1'b1, 16'd6};
    rows[14] = '{k_arith, e_br_eq,  16'h0001, 16'h0002, 1'b1, 16'h0003};
    // random rows alternate between a forward branch and a held loop.
    for (k = 0; k < num_random_lp; k++) begin
      r1 = next_random();
      r2 = next_random();
      if (k % 2 == 0) begin
        rows[num_fixed_lp + k].kind = k_fwd;
        rows[num_fixed_lp + k].bop  = branch_op_e'(r2[31:30]);
        rows[num_fixed_lp + k].a    = r1[15:0];
        rows[num_fixed_lp + k].b    = (r2[18:16] == 3'd0) ? r1[15:0] : r2[15:0];
        rows[num_fixed_lp + k].hold = 1'b0;
        rows[num_fixed_lp + k].exp_val =
          branch_holds(rows[num_fixed_lp + k].bop, rows[num_fixed_lp + k].a,
                       rows[num_fixed_lp + k].b) ? 16'd1 : 16'd2;
      end else begin
        rows[num_fixed_lp + k].kind    = k_loop;
        rows[num_fixed_lp + k].bop     = e_br_lt;
        rows[num_fixed_lp + k].a       = 16'd5 + r1[1:0];  // more sends than credits.
        rows[num_fixed_lp + k].b       = 16'd0;
        rows[num_fixed_lp + k].hold    = 1'b1;
        rows[num_fixed_lp + k].exp_val = rows[num_fixed_lp + k].a - 16'd1;
      end
    end
  endtask

  // turns one row into a program and its expected messages.
  task automatic build_program(input row_t r);
    int n;
    prog_q.delete();
    exp_q.delete();
    case (r.kind)
      k_arith: begin
        prog_q.push_back(encode(e_op_movi, e_br_eq, 3'd1, 3'd0, 3'd0, r.a));
        prog_q.push_back(encode(e_op_movi, e_br_eq, 3'd2, 3'd0, 3'd0, r.b));
        prog_q.push_back(encode(e_op_add,  e_br_eq, 3'd3, 3'd1, 3'd2, 16'd0));
        prog_q.push_back(encode(e_op_addi, e_br_eq, 3'd4, 3'd3, 3'd0, 16'd1));
        for (n = 1; n <= 4; n++) begin
          prog_q.push_back(encode(e_op_send, e_br_eq, 3'd0, reg_addr_t'(n), 3'd0, 16'd0));
        end
        prog_q.push_back(encode(e_op_halt, e_br_eq, 3'd0, 3'd0, 3'd0, 16'd0));
        exp_q = '{r.a, r.b, r.exp_val, gpr_t'(r.exp_val + 16'd1)};
      end
      k_fwd: begin
        prog_q.push_back(encode(e_op_movi, e_br_eq, 3'd1, 3'd0, 3'd0, r.a));
        prog_q.push_back(encode(e_op_movi, e_br_eq, 3'd2, 3'd0, 3'd0, r.b));
        prog_q.push_back(encode(e_op_movi, e_br_eq, 3'd5, 3'd0, 3'd0, 16'd1));
        prog_q.push_back(encode(e_op_movi, e_br_eq, 3'd6, 3'd0, 3'd0, 16'd2));
        prog_q.push_back(encode(e_op_branch, r.bop, 3'd0, 3'd1, 3'd2, 16'd7));  // to 7.
        prog_q.push_back(encode(e_op_send, e_br_eq, 3'd0, 3'd6, 3'd0, 16'd0));
        prog_q.push_back(encode(e_op_halt, e_br_eq, 3'd0, 3'd0, 3'd0, 16'd0));
        prog_q.push_back(encode(e_op_send, e_br_eq, 3'd0, 3'd5, 3'd0, 16'd0));
        prog_q.push_back(encode(e_op_halt, e_br_eq, 3'd0, 3'd0, 3'd0, 16'd0));
        exp_q.push_back(r.exp_val);
      end
      default: begin
        prog_q.push_back(encode(e_op_movi, e_br_eq, 3'd1, 3'd0, 3'd0, 16'd0));
        prog_q.push_back(encode(e_op_movi, e_br_eq, 3'd2, 3'd0, 3'd0, r.a));
        prog_q.push_back(encode(e_op_send, e_br_eq, 3'd0, 3'd1, 3'd0, 16'd0));
        prog_q.push_back(encode(e_op_addi, e_br_eq, 3'd1, 3'd1, 3'd0, 16'd1));
        prog_q.push_back(encode(e_op_branch, e_br_lt, 3'd0, 3'd1, 3'd2, 16'd2));  // back.
        prog_q.push_back(encode(e_op_halt, e_br_eq, 3'd0, 3'd0, 3'd0, 16'd0));
        for (n = 0; n <= r.exp_val; n++) begin
          exp_q.push_back(gpr_t'(n));
        end
      end
    endcase
  endtask

  // ====================
  // drivers and monitors
  // ====================
  task automatic load_program();
    int n;
    for (n = 0; n < prog_q.size(); n++) begin
      @(negedge clk);
      load_en   = 1'b1;
      load_addr = pc_t'(n);
      load_data = prog_q[n];
    end
    @(negedge clk);
    load_en = 1'b0;
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  // gathers messages for up to max_cycles, optionally stopping once halted is seen.
  task automatic collect(input int max_cycles, input bit stop_on_halt, output bit saw_halt);
    int n;
    n = 0;
    saw_halt = 1'b0;
    while (n < max_cycles && !saw_halt) begin
      @(negedge clk);
      if (msg_valid === 1'b1) got_q.push_back(msg_data);
      if (stop_on_halt && halted === 1'b1) saw_halt = 1'b1;
      n++;
    end
  endtask

  task automatic wait_credits_home();
    int n;
    n = 0;
    while (owed_q.size() != 0 && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (owed_q.size() != 0) begin
      $display("credits were still outstanding 50 cycles after the previous run");
      row_errors++;
    end
    @(negedge clk);  // the last returned credit lands in the counter here.
  endtask

  // every message owes one credit, returned 0 to 5 cycles later, one per cycle.
  always @(negedge clk) begin : credit_model
    int k;
    int due;
    due = -1;
    if (rst) begin
      owed_q.delete();
      credit = 1'b0;
    end else begin
      for (k = 0; k < owed_q.size(); k++) begin
        if (owed_q[k] > 0) owed_q[k] = owed_q[k] - 1;
      end
      if (msg_valid === 1'b1) owed_q.push_back(int'(next_random() % 6));
      for (k = 0; k < owed_q.size(); k++) begin
        if (due < 0 && owed_q[k] == 0) due = k;
      end
      if (!hold_credits && due >= 0) begin
        credit = 1'b1;
        owed_q.delete(due);
      end else begin
        credit = 1'b0;
      end
    end
  end

  // ====================
  // checks
  // ====================
  task automatic check_msg(input int idx, input gpr_t got, input gpr_t exp);
    if (got !== exp) begin
      $display("error at %0t ns: message %0d is %h, expected %h", $time, idx, got, exp);
      row_errors++;
    end
  endtask

  task automatic check_halt(input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t ns: halted_o is %b, expected %b", $time, got, exp);
      row_errors++;
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got != exp) begin
      $display("error at %0t ns: %0d messages seen, expected %0d", $time, got, exp);
      row_errors++;
    end
  endtask

  task automatic run_row(input int idx);
    row_t r;
    bit   saw_halt;
    int   n;
    int   held;
    r = rows[idx];
    row_errors = 0;
    got_q.delete();
    hold_credits = 1'b0;
    wait_credits_home();
    build_program(r);
    hold_credits = r.hold;  // set while idle, so no credit is in flight yet.
    load_program();
    pulse_start();
    if (r.hold) begin
      collect(40, 1'b0, saw_halt);
      held = (exp_q.size() < credits_lp) ? exp_q.size() : credits_lp;
      check_count(got_q.size(), held);
      hold_credits = 1'b0;
    end
    collect(150, 1'b1, saw_halt);
    if (!saw_halt) begin
      $display("test %0d: halted_o did not rise within 150 cycles", idx);
      row_errors++;
    end
    collect(10, 1'b0, saw_halt);  // nothing may follow the halt.
    check_halt(halted, 1'b1);
    check_count(got_q.size(), exp_q.size());
    for (n = 0; n < got_q.size() && n < exp_q.size(); n++) begin
      check_msg(n, got_q[n], exp_q[n]);
    end
    error_count += row_errors;
    if (row_errors == 0) rows_passed++;
    $display("test %0d %s: %s", idx, kind_name(r.kind), (row_errors == 0) ? "ok" : "mismatch");
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin : main_sequence
    int idx;
    rst          = 1'b1;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    start        = 1'b0;
    credit       = 1'b0;
    hold_credits = 1'b0;
    error_count  = 0;
    row_errors   = 0;
    rows_passed  = 0;
    fill_table();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_halt(halted, 1'b0);  // idle after reset, not halted.
    // every word gets a nop tagged with its own address.
    prog_q.delete();
    for (idx = 0; idx < (1 << `UCODE_PC_W); idx++) begin
      prog_q.push_back(encode(e_op_nop, e_br_eq, 3'd0, 3'd0, 3'd0, gpr_t'(16'ha500 | idx)));
    end
    load_program();
    error_count += row_errors;
    for (idx = 0; idx < num_rows_lp; idx++) begin
      run_row(idx);
    end
    if (uut.asserts.failures_seen != 0) begin
      $display("the bound checker flagged %0d assertion failures", uut.asserts.failures_seen);
      error_count += uut.asserts.failures_seen;
    end
    $display("%0d of %0d tests passed, %0d errors", rows_passed, num_rows_lp, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // 200 cycles per row bounds the whole run.
  initial begin : watchdog
    #(num_rows_lp * 200 * 2 * clk_half_lp);
    $display("watchdog expired before the test sequence finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+source
source/ucode_pkg.sv
source/ucode_fetch.sv
source/ucode_regfile.sv
source/ucode_branch.sv
source/ucode_execute.sv
source/ucode_engine.sv
tb/ucode_engine_asserts.sv
tb/ucode_engine_tb.sv
